/* cpu_config.svh */
// CPU size parameters
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath width, registers and memory bytes
`define CPU_DATA_W 8

// Bus address width, 256-byte shared memory
`define CPU_ADDR_W 8

// Retired instruction counter
`define CPU_CC_W 16

// First fetch address after reset
`define CPU_RESET_PC 8'd33

// General registers r0..r3
`define CPU_NREG 4
`define CPU_REG_IDX_W 2

`endif

/* cpu_pkg.sv */
// CPU shared types
`include "cpu_config.svh"

package cpu_pkg;

    // Instruction opcodes, bits 7:4 of ir
    typedef enum logic [3:0] {
        NOP   = 4'b0000,    // Also HALT when low bits are 1111
        ADD   = 4'b0001,
        ADDI  = 4'b0010,
        SUB   = 4'b0011,
        MUL   = 4'b0100,    // Executes as NOP
        NEG   = 4'b0110,
        BGEZ0 = 4'b1000,    // Executes as NOP
        BGEZ1 = 4'b1001,    // Executes as NOP
        MOVE  = 4'b1010,
        STORE = 4'b1011,
        LOAD  = 4'b1100,
        LOADI = 4'b1101,
        JUMP  = 4'b1110,
        OP_F  = 4'b1111     // Executes as NOP
    } opcode_t;

    typedef enum logic [1:0] {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_HALT
    } cpu_state_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_NEG,
        ALU_PASS,   // y = b
        ALU_ADDI    // b holds a 2-bit immediate
    } alu_op_t;

    // Wishbone master to slave
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`CPU_ADDR_W-1:0] adr;
        logic [`CPU_DATA_W-1:0] dat;
    } wb_m2s_t;

    // Wishbone slave to master
    typedef struct packed {
        logic                   ack;
        logic [`CPU_DATA_W-1:0] dat;
    } wb_s2m_t;

    // One memory access from control to the bus master
    typedef struct packed {
        logic                   we;
        logic [`CPU_ADDR_W-1:0] adr;
        logic [`CPU_DATA_W-1:0] dat;
    } mem_req_t;

endpackage

/* cpu_alu.sv */
// CPU arithmetic unit
module cpu_alu #(
    parameter int W = 8
) (
    input  cpu_pkg::alu_op_t op,
    input  logic [W-1:0]     a,
    input  logic [W-1:0]     b,
    output logic [W-1:0]     y
);
    logic [W-1:0] imm;

    // Only the low two bits carry the immediate
    assign imm = {{(W-2){1'b0}}, b[1:0]};

    // All results wrap at W bits
    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:  y = a + b;
            cpu_pkg::ALU_SUB:  y = a - b;
            cpu_pkg::ALU_NEG:  y = '0 - a;     // Two's complement
            cpu_pkg::ALU_PASS: y = b;
            cpu_pkg::ALU_ADDI: y = a + imm;
            default:           y = b;
        endcase
    end

endmodule

/* cpu_regfile.sv */
// General register file
`include "cpu_config.svh"

module cpu_regfile (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`CPU_REG_IDX_W-1:0] ra,
    input  logic [`CPU_REG_IDX_W-1:0] rb,
    output logic [`CPU_DATA_W-1:0]    rdata_a,
    output logic [`CPU_DATA_W-1:0]    rdata_b,
    input  logic                      we,
    input  logic [`CPU_REG_IDX_W-1:0] waddr,
    input  logic [`CPU_DATA_W-1:0]    wdata
);
    logic [`CPU_DATA_W-1:0] regs [`CPU_NREG];

    // Reads see the old value during a write
    assign rdata_a = regs[ra];
    assign rdata_b = regs[rb];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

/* wb_master.sv */
// Wishbone classic bus master
`include "cpu_config.svh"

module wb_master (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  cpu_pkg::mem_req_t      mem_req,
    output logic                   done,
    output logic [`CPU_DATA_W-1:0] rdata,
    output cpu_pkg::wb_m2s_t       bus_out,
    input  cpu_pkg::wb_s2m_t       bus_in
);
    logic armed;    // Req seen low since the last start

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_out <= '0;
            done    <= 1'b0;
            armed   <= 1'b1;
        end else begin
            done <= 1'b0;
            if (!req) begin
                armed <= 1'b1;
            end
            if (bus_out.cyc) begin
                // Hold everything until the slave acks
                if (bus_in.ack) begin
                    bus_out.cyc <= 1'b0;
                    bus_out.stb <= 1'b0;
                    bus_out.we  <= 1'b0;
                    done        <= 1'b1;
                end
            end else if (req && armed) begin
                bus_out.cyc <= 1'b1;
                bus_out.stb <= 1'b1;
                bus_out.we  <= mem_req.we;
                bus_out.adr <= mem_req.adr;
                bus_out.dat <= mem_req.dat;
                armed       <= 1'b0;
            end
        end
    end

    // Read data captured in the ack cycle
    always_ff @(posedge clk) begin
        if (bus_out.cyc && bus_in.ack) begin
            rdata <= bus_in.dat;
        end
    end

endmodule

/* cpu_control.sv */
// CPU fetch and execute control
`include "cpu_config.svh"

module cpu_control (
    input  logic                      clk,
    input  logic                      rst,
    output logic [`CPU_REG_IDX_W-1:0] ra,
    output logic [`CPU_REG_IDX_W-1:0] rb,
    input  logic [`CPU_DATA_W-1:0]    rdata_a,
    input  logic [`CPU_DATA_W-1:0]    rdata_b,
    output logic                      reg_we,
    output logic [`CPU_REG_IDX_W-1:0] waddr,
    output logic [`CPU_DATA_W-1:0]    wdata,
    output cpu_pkg::alu_op_t          alu_op,
    output logic [`CPU_DATA_W-1:0]    alu_a,
    output logic [`CPU_DATA_W-1:0]    alu_b,
    input  logic [`CPU_DATA_W-1:0]    alu_y,
    output logic                      req,
    output cpu_pkg::mem_req_t         mem_req,
    input  logic                      done,
    input  logic [`CPU_DATA_W-1:0]    rdata,
    output logic                      halt,
    output logic [`CPU_CC_W-1:0]      cc
);
    cpu_pkg::cpu_state_t    state;
    cpu_pkg::opcode_t       op;
    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] ir;
    logic [`CPU_DATA_W-1:0] imm;
    logic                   is_halt;
    logic                   is_mem;
    logic                   exec_wr;    // Register write in S_EXEC

    assign op      = cpu_pkg::opcode_t'(ir[7:4]);
    assign imm     = {{(`CPU_DATA_W-2){1'b0}}, ir[1:0]};
    assign is_halt = (op == cpu_pkg::NOP) && (ir[3:0] == 4'b1111);
    assign is_mem  = (op == cpu_pkg::LOAD) || (op == cpu_pkg::STORE);

    // LOAD takes its page bits from r3
    assign ra = ir[3:2];
    assign rb = (op == cpu_pkg::LOAD) ? '1 : ir[1:0];

    // Decode into ALU operation and write target
    always_comb begin
        alu_op  = cpu_pkg::ALU_PASS;
        alu_a   = rdata_a;
        alu_b   = rdata_b;
        waddr   = ir[3:2];
        exec_wr = 1'b0;
        case (op)
            cpu_pkg::ADD: begin
                alu_op  = cpu_pkg::ALU_ADD;
                waddr   = '0;           // Result always in r0
                exec_wr = 1'b1;
            end
            cpu_pkg::SUB: begin
                alu_op  = cpu_pkg::ALU_SUB;
                waddr   = '0;
                exec_wr = 1'b1;
            end
            cpu_pkg::NEG: begin
                alu_op  = cpu_pkg::ALU_NEG;
                waddr   = '0;
                exec_wr = 1'b1;
            end
            cpu_pkg::ADDI: begin
                alu_op  = cpu_pkg::ALU_ADDI;
                alu_b   = imm;
                exec_wr = 1'b1;
            end
            cpu_pkg::MOVE: begin
                exec_wr = 1'b1;         // rd = rs through pass
            end
            cpu_pkg::LOADI: begin
                alu_b   = imm;
                exec_wr = 1'b1;
            end
            cpu_pkg::LOAD: begin
                waddr = '0;             // Written when the bus read ends
            end
            cpu_pkg::JUMP: begin
                // Return address pc + 1 into r3
                alu_op  = cpu_pkg::ALU_ADD;
                alu_a   = pc;
                alu_b   = `CPU_DATA_W'(1);
                waddr   = '1;
                exec_wr = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign reg_we = ((state == cpu_pkg::S_EXEC) && exec_wr) ||
                    ((state == cpu_pkg::S_MEM) && done && (op == cpu_pkg::LOAD));
    assign wdata  = (state == cpu_pkg::S_MEM) ? rdata : alu_y;

    // Request drops in the cycle done is seen
    assign req = ((state == cpu_pkg::S_FETCH) || (state == cpu_pkg::S_MEM)) && !done;

    always_comb begin
        mem_req.we  = (state == cpu_pkg::S_MEM) && (op == cpu_pkg::STORE);
        mem_req.dat = rdata_b;                      // rs for STORE
        if (state == cpu_pkg::S_FETCH) begin
            mem_req.adr = pc;
        end else if (op == cpu_pkg::STORE) begin
            mem_req.adr = rdata_a;
        end else begin
            mem_req.adr = {2'b00, rdata_b[1:0], ir[3:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cpu_pkg::S_FETCH;
            pc    <= `CPU_RESET_PC;
            ir    <= '0;
            cc    <= '0;
            halt  <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::S_FETCH: begin
                    if (done) begin
                        ir    <= rdata;
                        state <= cpu_pkg::S_EXEC;
                    end
                end
                cpu_pkg::S_EXEC: begin
                    if (is_halt) begin
                        halt  <= 1'b1;
                        cc    <= cc + 1'b1;     // HALT retires too
                        state <= cpu_pkg::S_HALT;
                    end else if (is_mem) begin
                        state <= cpu_pkg::S_MEM;
                    end else begin
                        cc    <= cc + 1'b1;
                        pc    <= (op == cpu_pkg::JUMP) ? rdata_a : pc + 1'b1;
                        state <= cpu_pkg::S_FETCH;
                    end
                end
                cpu_pkg::S_MEM: begin
                    if (done) begin
                        cc    <= cc + 1'b1;
                        pc    <= pc + 1'b1;
                        state <= cpu_pkg::S_FETCH;
                    end
                end
                default: begin
                    // Stuck in S_HALT until reset
                end
            endcase
        end
    end

endmodule

/* cpu_top.sv */
// CPU top level
`include "cpu_config.svh"

module cpu_top (
    input  logic                  clk,
    input  logic                  rst,
    output cpu_pkg::wb_m2s_t      bus_out,
    input  cpu_pkg::wb_s2m_t      bus_in,
    output logic                  halt,
    output logic [`CPU_CC_W-1:0]  cc
);
    logic [`CPU_REG_IDX_W-1:0] ra;
    logic [`CPU_REG_IDX_W-1:0] rb;
    logic [`CPU_DATA_W-1:0]    rdata_a;
    logic [`CPU_DATA_W-1:0]    rdata_b;
    logic                      reg_we;
    logic [`CPU_REG_IDX_W-1:0] waddr;
    logic [`CPU_DATA_W-1:0]    wdata;
    cpu_pkg::alu_op_t          alu_op;
    logic [`CPU_DATA_W-1:0]    alu_a;
    logic [`CPU_DATA_W-1:0]    alu_b;
    logic [`CPU_DATA_W-1:0]    alu_y;
    logic                      req;     // Held until done
    cpu_pkg::mem_req_t         mem_req;
    logic                      done;
    logic [`CPU_DATA_W-1:0]    rdata;   // Fetched or loaded byte

    cpu_control u_control (
        .clk     (clk),
        .rst     (rst),
        .ra      (ra),
        .rb      (rb),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .reg_we  (reg_we),
        .waddr   (waddr),
        .wdata   (wdata),
        .alu_op  (alu_op),
        .alu_a   (alu_a),
        .alu_b   (alu_b),
        .alu_y   (alu_y),
        .req     (req),
        .mem_req (mem_req),
        .done    (done),
        .rdata   (rdata),
        .halt    (halt),
        .cc      (cc)
    );

    cpu_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .ra      (ra),
        .rb      (rb),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (reg_we),
        .waddr   (waddr),
        .wdata   (wdata)
    );

    cpu_alu #(.W(`CPU_DATA_W)) u_alu (
        .op (alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    wb_master u_bus (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .mem_req (mem_req),
        .done    (done),
        .rdata   (rdata),
        .bus_out (bus_out),
        .bus_in  (bus_in)
    );

endmodule

/* cpu_assertions.sv */
// Bus and halt assertions
module cpu_assertions (
    input logic             clk,
    input logic             rst,
    input cpu_pkg::wb_m2s_t bus_out,
    input cpu_pkg::wb_s2m_t bus_in,
    input logic             halt
);
    timeunit 1ns;
    timeprecision 1ps;

    stb_needs_cyc: assert property (@(posedge clk) disable iff (rst)
        bus_out.stb |-> bus_out.cyc)
        else $error("stb high without cyc");

    // Request fields frozen until the slave acks
    hold_until_ack: assert property (@(posedge clk) disable iff (rst)
        (bus_out.stb && !bus_in.ack) |=> (bus_out.stb && $stable(bus_out.adr) &&
        $stable(bus_out.we) && $stable(bus_out.dat)))
        else $error("bus request changed before ack");

    no_cycle_halted: assert property (@(posedge clk) disable iff (rst)
        halt |-> !$rose(bus_out.cyc))
        else $error("bus cycle started while halted");

    halt_sticky: assert property (@(posedge clk)
        $fell(halt) |-> $past(rst))
        else $error("halt fell without reset");

endmodule

bind cpu_top cpu_assertions u_asrt (
    .clk     (clk),
    .rst     (rst),
    .bus_out (bus_out),
    .bus_in  (bus_in),
    .halt    (halt)
);

/* tb_cpu.sv */
// CPU testbench
`include "cpu_config.svh"

module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    logic                  clk;
    logic                  rst;
    cpu_pkg::wb_m2s_t      bus_out;
    cpu_pkg::wb_s2m_t      bus_in;
    logic                  halt;
    logic [`CPU_CC_W-1:0]  cc;

    logic [7:0]  mem [256];         // Shared code and data memory
    logic [15:0] seen_wr [$];       // {adr, dat} of each bus write
    logic [15:0] exp_wr [$];
    int          errors;
    int          test_errors;
    int          waits;
    int          hold_cycles;
    logic        active;

    cpu_top u_dut (
        .clk     (clk),
        .rst     (rst),
        .bus_out (bus_out),
        .bus_in  (bus_in),
        .halt    (halt),
        .cc      (cc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // Wishbone slave with 0 to 3 random wait states
    always @(posedge clk) begin
        if (rst) begin
            bus_in.ack <= 1'b0;
            active = 1'b0;
            hold_cycles = 0;
        end else begin
            // Length of the current bus cycle
            if (bus_out.cyc) begin
                hold_cycles++;
            end else begin
                hold_cycles = 0;
            end
            if (hold_cycles > 16) begin
                $display("Timeout: bus cycle at address %0h never finished", bus_out.adr);
                errors++;
                test_errors++;
                hold_cycles = 0;
            end
            if (bus_in.ack) begin
                bus_in.ack <= 1'b0;
                active = 1'b0;
            end else if (bus_out.cyc && bus_out.stb) begin
                if (!active) begin
                    active = 1'b1;
                    waits = $urandom % 4;
                end
                if (waits == 0) begin
                    bus_in.ack <= 1'b1;
                    bus_in.dat <= mem[bus_out.adr];
                    if (bus_out.we) begin
                        mem[bus_out.adr] = bus_out.dat;
                        seen_wr.push_back({bus_out.adr, bus_out.dat});
                    end
                end else begin
                    waits--;
                end
            end
        end
    end

    task automatic run_test(input logic [8*16-1:0] name, input int exp_cc, input int limit);
        int cycles;
        int cc_at_halt;
        test_errors = 0;
        @(posedge clk);
        rst <= 1'b1;
        repeat (8) @(posedge clk);
        seen_wr.delete();
        rst <= 1'b0;
        cycles = 0;
        while (!halt && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halt) begin
            $display("Timeout: test %0s did not halt within %0d cycles", name, limit);
            errors++;
            test_errors++;
        end
        check_value("retired count", cc, exp_cc);
        cc_at_halt = cc;
        // Core must stay quiet once halted
        repeat (10) begin
            @(negedge clk);
            check_value("cyc after halt", bus_out.cyc, 0);
        end
        check_value("cc after halt", cc, cc_at_halt);
        check_value("write count", seen_wr.size(), exp_wr.size());
        for (int i = 0; i < exp_wr.size() && i < seen_wr.size(); i++) begin
            check_value("write address", seen_wr[i][15:8], exp_wr[i][15:8]);
            check_value("write data", seen_wr[i][7:0], exp_wr[i][7:0]);
        end
        if (test_errors == 0) $display("test %0s: ok, cc %0d", name, cc);
        else $display("test %0s: failed with %0d errors", name, test_errors);
    endtask

    initial begin
        int fd;
        int n;
        int tests;
        int failed;
        int exp_cc;
        int limit;
        int cnt;
        logic [7:0] adr;
        logic [7:0] dat;
        logic [8*16-1:0] kw;
        logic [8*16-1:0] name;
        logic [8*128-1:0] line;
        logic eof;
        rst = 1'b1;
        bus_in = '0;
        errors = 0;
        tests = 0;
        failed = 0;
        void'($urandom(8357));
        fd = $fopen("cpu_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file cpu_vectors.txt");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            eof = 1'b0;
            while (!eof) begin
                n = $fscanf(fd, "%s", kw);
                if (n != 1) begin
                    eof = 1'b1;
                end else if (kw == "#") begin
                    n = $fgets(line, fd);
                end else if (kw == "T") begin
                    n = $fscanf(fd, "%s", name);
                    exp_wr.delete();
                    for (int a = 0; a < 256; a++) mem[a] = 8'(a) ^ 8'h5a;
                end else if (kw == "M") begin
                    n = $fscanf(fd, "%h %d", adr, cnt);
                    for (int i = 0; i < cnt; i++) begin
                        n = $fscanf(fd, "%h", dat);
                        mem[adr + 8'(i)] = dat;
                    end
                end else if (kw == "W") begin
                    n = $fscanf(fd, "%h %h", adr, dat);
                    exp_wr.push_back({adr, dat});
                end else if (kw == "E") begin
                    n = $fscanf(fd, "%d %d", exp_cc, limit);
                    run_test(name, exp_cc, limit);
                    tests++;
                    if (test_errors != 0) failed++;
                end
            end
            $fclose(fd);
            $display("Tests %0d, passed %0d, failed %0d, errors %0d",
                     tests, tests - failed, failed, errors);
            if (errors == 0 && tests > 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

/* cpu_vectors.txt */
# T name | M start_addr count bytes... (hex) | W store_addr store_data (hex)
# E expected_cc cycle_limit (decimal), runs the test
T basic
M 21 7 d7 26 a9 de be b7 0f
W 02 05
W 05 02
E 7 400
T arith
M 21 13 d7 d9 16 ac 39 bc 64 2d bc 10 2d bc 0f
W 04 fe
W 05 fd
W 06 fa
E 13 600
T load
M 17 1 9c
M 21 9 dd c7 d7 b4 de c3 da b8 0f
W 03 9c
W 02 d7
E 9 500
T jump
M 00 1 30
M 21 5 c0 e0 b0 b0 0f
M 30 3 d5 b7 0f
W 01 23
E 5 400
T nops
M 21 9 d7 45 8a 9f f3 0e da b9 0f
W 02 03
E 9 400

/* verilog.f */
+incdir+.
cpu_pkg.sv
cpu_alu.sv
cpu_regfile.sv
wb_master.sv
cpu_control.sv
cpu_top.sv
cpu_assertions.sv
tb_cpu.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_cpu
FILELIST = verilog.f

SRCS = $(shell grep -v '^+' $(FILELIST)) cpu_config.svh
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
